// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart_cmd testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_cmd_tb -f uart_cmd.f -o uart_cmd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/uart_cmd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0

// ==== sim/uart_cmd_sva.sv ====
`default_nettype none

module uart_cmd_sva (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic tx_busy,
  input logic tx_start,
  input logic read_rdy
);

  ////////////////////////////////////////////////////////////
  // bridge protocol
  ////////////////////////////////////////////////////////////
  reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> tx && cmd_rdy && !read_rdy && !tx_busy)
    else $error("bridge not idle after reset");

  line_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx low with no frame in progress");

  busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else $error("cmd_rdy still high after acceptance");

  // ready again only once the serializer is done
  ready_when_done: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> !tx_busy && !tx_start)
    else $error("cmd_rdy rose during a frame");

  start_when_free: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start while serializer busy");

  single_read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles");

endmodule

bind uart_cmd_top uart_cmd_sva sva_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .tx_busy  (tx_busy),
  .tx_start (tx_start),
  .read_rdy (read_rdy)
);

`default_nettype wire

// ==== sim/uart_cmd_tb.sv ====
`default_nettype none

module uart_cmd_tb;

  localparam int  CLK_PERIOD = 8;
  localparam int  CPB        = uart_pkg::CLKS_PER_BIT;
  localparam int  N_WR       = 5;
  localparam int  N_RD       = 6;
  localparam int  WR_CYCLES  = (22 + uart_pkg::GAP_BITS) * CPB + 3;
  // header, full timeout window and response frame
  localparam int  RD_CYCLES  = (2 * uart_pkg::FRAME_BITS + uart_pkg::RESP_TIMEOUT_BITS) * CPB + 8;
  localparam int  WATCHDOG_T = 2 * CLK_PERIOD *
                               (8 + N_WR * (WR_CYCLES + 4) + N_RD * (RD_CYCLES + 4));
  localparam time MIN_DATA_T = time'((uart_pkg::FRAME_BITS + uart_pkg::GAP_BITS) * CPB * CLK_PERIOD);

  typedef struct packed {
    logic       is_data;  // second frame of a write
    logic [7:0] value;
  } frame_exp_t;

  typedef enum logic [1:0] {RESP_OK, RESP_BAD_PARITY, RESP_SILENT} resp_mode_t;

  logic           clk;
  logic           rst_n;
  uart_pkg::cmd_t cmd_in;
  logic           cmd_vld;
  logic           rx;
  logic           cmd_rdy;
  logic           tx;
  logic           read_rdy;
  logic [7:0]     read_data;
  logic           read_err;

  frame_exp_t     exp_q[$];
  logic [7:0]     mon_data;   // last decoded frame
  logic           mon_par;
  logic           mon_stop;
  time            hdr_start_t;
  event           read_hdr_seen;
  resp_mode_t     resp_mode;
  logic [7:0]     resp_byte;
  int             resp_delay;  // bit times before the response

  uart_cmd_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
  endtask

  function automatic string mismatch_line(input string msg);
    return $sformatf("MISMATCH at time %0t: %s", $time, msg);
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin : watchdog
    #(WATCHDOG_T);
    fail_now("watchdog expired before all commands finished");
  end

  read_with_ready: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> cmd_rdy)
    else fail_now(mismatch_line("read_rdy high while cmd_rdy low"));

  ////////////////////////////////////////////////////////////
  // serial monitor on tx
  ////////////////////////////////////////////////////////////
  initial
  begin : serial_monitor
    logic [uart_pkg::FRAME_BITS-1:0] bits;
    frame_exp_t                      exp;
    time                             start_t;
    forever
    begin
      @(negedge tx);
      start_t = $time;
      repeat (CPB / 2) @(negedge clk);  // mid start bit
      bits[0] = tx;
      for (int i = 1; i < uart_pkg::FRAME_BITS; i++)
      begin
        repeat (CPB) @(negedge clk);
        bits[i] = tx;
      end
      {mon_stop, mon_par, mon_data} = bits[uart_pkg::FRAME_BITS-1:1];
      assert (bits[0] == uart_pkg::START_BIT)
        else fail_now(mismatch_line("start bit not low at mid-bit"));
      assert (exp_q.size() > 0) else fail_now("frame on tx with no frame expected");
      exp = exp_q.pop_front();
      assert (mon_data == exp.value)
        else fail_now(mismatch_line($sformatf("frame %h, expected %h", mon_data, exp.value)));
      assert ((^{mon_data, mon_par}) == 1'b0)
        else fail_now(mismatch_line("frame parity is odd"));
      assert (mon_stop == uart_pkg::STOP_BIT) else fail_now(mismatch_line("stop bit low"));
      if (exp.is_data)
      begin
        assert (start_t - hdr_start_t >= MIN_DATA_T)
          else fail_now(mismatch_line("idle gap before data frame too short"));
      end
      else
        hdr_start_t = start_t;
      if (!exp.is_data && !mon_data[7])
        -> read_hdr_seen;
    end
  end

  ////////////////////////////////////////////////////////////
  // peripheral responder on rx
  ////////////////////////////////////////////////////////////
  initial
  begin : responder
    logic [uart_pkg::FRAME_BITS-1:0] frame;
    rx = 1'b1;
    forever
    begin
      @(read_hdr_seen);
      frame = {uart_pkg::STOP_BIT, ^resp_byte, resp_byte, uart_pkg::START_BIT};
      if (resp_mode == RESP_BAD_PARITY)
        frame[uart_pkg::FRAME_BITS-2] = ~frame[uart_pkg::FRAME_BITS-2];
      repeat (resp_delay * CPB) @(negedge clk);
      if (resp_mode != RESP_SILENT)
      begin
        for (int i = 0; i < uart_pkg::FRAME_BITS; i++)
        begin
          rx = frame[i];
          repeat (CPB) @(negedge clk);
        end
      end
    end
  end

  // one command from acceptance to cmd_rdy, with stray strobes while busy
  task automatic run_cmd(input uart_pkg::cmd_t cmd, input resp_mode_t mode, input logic [7:0] resp);
    int n;
    n = 0;
    resp_mode  = mode;
    resp_byte  = resp;
    resp_delay = 1 + $urandom % 10;
    exp_q.push_back({1'b0, cmd.wr, cmd.addr});
    if (cmd.wr)
      exp_q.push_back({1'b1, cmd.data});
    @(negedge clk);
    assert (cmd_rdy) else fail_now("bridge not ready for a new command");
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
    begin
      n++;
      cmd_vld = (n % 40 == 7);
      cmd_in  = 16'($urandom);
      assert (!read_rdy) else fail_now(mismatch_line("read_rdy while busy"));
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    if (cmd.wr)
    begin
      assert (n == WR_CYCLES)
        else fail_now(mismatch_line($sformatf("write took %0d cycles, expected %0d", n, WR_CYCLES)));
      assert (!read_rdy) else fail_now(mismatch_line("read_rdy after a write"));
    end
    else
    begin
      assert (read_rdy) else fail_now(mismatch_line("no read_rdy when cmd_rdy rose"));
      assert (read_err == (mode != RESP_OK))
        else fail_now(mismatch_line($sformatf("read_err %b in response mode %0d", read_err, mode)));
      if (mode != RESP_BAD_PARITY)
      begin
        assert (read_data == ((mode == RESP_SILENT) ? 8'h00 : resp))
          else fail_now(mismatch_line($sformatf("read_data %h, sent %h", read_data, resp)));
      end
    end
    assert (exp_q.size() == 0) else fail_now("an expected frame was never sent");
  endtask

  ////////////////////////////////////////////////////////////
  // host
  ////////////////////////////////////////////////////////////
  initial
  begin : host
    uart_pkg::cmd_t cmd;
    void'($urandom(32'h3609_cec7));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (tx && cmd_rdy && !read_rdy)
      else fail_now(mismatch_line("outputs not idle after reset"));
    for (int i = 0; i < 4; i++)
    begin
      cmd    = 16'($urandom);
      cmd.wr = 1'b1;
      run_cmd(cmd, RESP_OK, 8'h00);
      cmd    = 16'($urandom);
      cmd.wr = 1'b0;
      run_cmd(cmd, RESP_OK, 8'($urandom));
    end
    cmd    = 16'($urandom);
    cmd.wr = 1'b0;
    run_cmd(cmd, RESP_BAD_PARITY, 8'($urandom));
    run_cmd(cmd, RESP_SILENT, 8'($urandom));  // timeout path
    cmd    = 16'($urandom);
    cmd.wr = 1'b1;
    run_cmd(cmd, RESP_OK, 8'h00);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/uart_cmd_ctrl.sv ====
`default_nettype none

module uart_cmd_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::cmd_t       cmd_in,
  input  logic                 cmd_vld,
  input  logic                 tx_busy,
  input  logic                 rx_valid,
  input  uart_pkg::rx_result_t rx_result,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output logic [7:0]           tx_byte,
  output logic                 read_rdy,
  output uart_pkg::read_resp_t read_resp
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HEADER,
    S_GAP,
    S_DATA,
    S_WAIT
  } ctrl_state_t;

  ctrl_state_t                     state;
  logic [uart_pkg::TIMER_W-1:0]    timer;   // gap and response timeout
  logic                            is_wr;
  logic [uart_pkg::DATA_BITS-1:0]  wr_data;
  logic                            accept;
  logic                            frame_done;
  logic                            gap_done;
  logic                            timeout;

  assign cmd_rdy    = (state == S_IDLE);
  assign accept     = cmd_vld & cmd_rdy;
  // tx_busy only rises a cycle after tx_start
  assign frame_done = ~tx_start & ~tx_busy;
  assign gap_done   = (state == S_GAP) && (timer == uart_pkg::GAP_LAST);
  assign timeout    = (timer == uart_pkg::WAIT_LAST);

  ////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      timer    <= '0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (accept)
          begin
            tx_start <= 1'b1;  // header frame
            state    <= S_HEADER;
          end
        end
        S_HEADER:
        begin
          if (frame_done)
          begin
            timer <= '0;
            state <= is_wr ? S_GAP : S_WAIT;
          end
        end
        S_GAP:
        begin
          if (gap_done)
          begin
            tx_start <= 1'b1;  // data frame
            state    <= S_DATA;
          end
          else
            timer <= timer + 1'b1;
        end
        S_DATA:
        begin
          if (frame_done)
            state <= S_IDLE;
        end
        S_WAIT:
        begin
          if (rx_valid || timeout)
          begin
            read_rdy <= 1'b1;
            state    <= S_IDLE;
          end
          else
            timer <= timer + 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // command and result payload
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tx_byte <= {cmd_in.wr, cmd_in.addr};
      is_wr   <= cmd_in.wr;
      wr_data <= cmd_in.data;
    end
    else if (gap_done)
      tx_byte <= wr_data;

    if (state == S_WAIT)
    begin
      if (rx_valid)
      begin
        read_resp.data <= rx_result.data;
        read_resp.err  <= rx_result.parity_err | rx_result.stop_err;
      end
      else if (timeout)
      begin
        read_resp.data <= '0;  // no response
        read_resp.err  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_cmd_top.sv ====
`default_nettype none

module uart_cmd_top (
  input  logic           clk,
  input  logic           rst_n,
  input  uart_pkg::cmd_t cmd_in,
  input  logic           cmd_vld,
  input  logic           rx,
  output logic           cmd_rdy,
  output logic           tx,
  output logic           read_rdy,
  output logic [7:0]     read_data,
  output logic           read_err
);

  logic                 rx_valid;
  uart_pkg::rx_result_t rx_result;
  logic                 tx_start;
  logic [7:0]           tx_byte;
  logic                 tx_busy;
  uart_pkg::read_resp_t read_resp;

  uart_rx rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

  uart_cmd_ctrl ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_busy   (tx_busy),
    .rx_valid  (rx_valid),
    .rx_result (rx_result),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  uart_tx tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  assign read_data = read_resp.data;
  assign read_err  = read_resp.err;

endmodule

`default_nettype wire

// ==== src/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  ////////////////////////////////////////////////////////////
  // bit timing
  ////////////////////////////////////////////////////////////
  localparam int CLKS_PER_BIT      = 16;  // at least 4
  localparam int DATA_BITS         = 8;
  localparam int GAP_BITS          = 2;   // idle bit times between write frames
  localparam int RESP_TIMEOUT_BITS = 40;  // window for the response start

  localparam int FRAME_BITS       = DATA_BITS + 3;  // start, data, parity, stop
  localparam int GAP_CYCLES       = GAP_BITS * CLKS_PER_BIT;
  // a response starting late in the window still gets its whole frame in
  localparam int RESP_WAIT_CYCLES = (RESP_TIMEOUT_BITS + FRAME_BITS) * CLKS_PER_BIT;

  localparam int CNT_W     = $clog2(CLKS_PER_BIT);
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);
  localparam int TIMER_W   = $clog2(RESP_WAIT_CYCLES);

  localparam logic [CNT_W-1:0]     BIT_LAST   = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0]     HALF_LAST  = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [BIT_CNT_W-1:0] FRAME_LAST = BIT_CNT_W'(FRAME_BITS - 1);
  localparam logic [BIT_CNT_W-1:0] DATA_LAST  = BIT_CNT_W'(DATA_BITS - 1);
  localparam logic [TIMER_W-1:0]   GAP_LAST   = TIMER_W'(GAP_CYCLES - 2);
  localparam logic [TIMER_W-1:0]   WAIT_LAST  = TIMER_W'(RESP_WAIT_CYCLES - 1);

  // line levels
  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT  = 1'b1;

  ////////////////////////////////////////////////////////////
  // payload structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                 wr;    // bit 15, 1 = write
    logic [DATA_BITS-2:0] addr;
    logic [DATA_BITS-1:0] data;
  } cmd_t;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 parity_err;
    logic                 stop_err;
  } rx_result_t;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 err;
  } read_resp_t;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
`default_nettype none

module uart_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 rx_valid,
  output uart_pkg::rx_result_t rx_result
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t                          state;
  logic                               rx_s1;
  logic                               rx_s2;
  logic                               rx_d;
  logic                               fall;
  logic [uart_pkg::CNT_W-1:0]         clk_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0]     bit_idx;
  logic                               bit_end;
  logic [uart_pkg::DATA_BITS-1:0]     shreg;
  logic                               par_bit;

  ////////////////////////////////////////////////////////////
  // synchronizer and start edge
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  assign fall    = rx_d & ~rx_s2;
  assign bit_end = (clk_cnt == uart_pkg::BIT_LAST);

  ////////////////////////////////////////////////////////////
  // frame fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          clk_cnt <= '0;
          if (fall)
            state <= RX_START;
        end
        RX_START:  // recheck at mid start bit, drop glitches
        begin
          if (clk_cnt == uart_pkg::HALF_LAST)
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= (rx_s2 == uart_pkg::START_BIT) ? RX_DATA : RX_IDLE;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        RX_DATA:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (bit_idx == uart_pkg::DATA_LAST)
              state <= RX_PARITY;
            else
              bit_idx <= bit_idx + 1'b1;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end
        RX_PARITY:
        begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end)
            state <= RX_STOP;
        end
        RX_STOP:
        begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end)
          begin
            rx_valid <= 1'b1;
            state    <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // sampled bits, lsb first
  always_ff @(posedge clk)
  begin
    if (bit_end)
    begin
      case (state)
        RX_DATA:   shreg   <= {rx_s2, shreg[uart_pkg::DATA_BITS-1:1]};
        RX_PARITY: par_bit <= rx_s2;
        RX_STOP:
        begin
          rx_result.data       <= shreg;
          rx_result.parity_err <= ^{shreg, par_bit};  // even parity expected
          rx_result.stop_err   <= (rx_s2 != uart_pkg::STOP_BIT);
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  logic [uart_pkg::FRAME_BITS-1:0] frame_q;   // bit 0 is on the line
  logic [uart_pkg::CNT_W-1:0]      clk_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic                            bit_end;

  assign bit_end = (clk_cnt == uart_pkg::BIT_LAST);
  assign tx      = frame_q[0];  // all ones while idle

  ////////////////////////////////////////////////////////////
  // frame serializer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_q <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end
    else if (tx_start && !tx_busy)
    begin
      // even parity: the parity bit makes the count of ones even
      frame_q <= {uart_pkg::STOP_BIT, ^tx_byte, tx_byte, uart_pkg::START_BIT};
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b1;
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        clk_cnt <= '0;
        frame_q <= {uart_pkg::STOP_BIT, frame_q[uart_pkg::FRAME_BITS-1:1]};
        if (bit_cnt == uart_pkg::FRAME_LAST)
        begin
          bit_cnt <= '0;
          tx_busy <= 1'b0;  // stop bit fully held
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
      else
        clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== uart_cmd.f ====
src/uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_cmd_ctrl.sv
src/uart_cmd_top.sv
sim/uart_cmd_sva.sv
sim/uart_cmd_tb.sv
